// File: design/sprite_pkg.sv
// shared constants for the sprite display
// coordinate width, register map, register word union, reset defaults

package sprite_pkg;

    // signed screen coordinate width
    parameter int cord_w = 16;

    // active area
    parameter int h_res = 640;  // pixels per line
    parameter int v_res = 480;  // lines per frame

    // register addresses
    parameter logic [1:0] reg_addr_pos = 2'd0;  // x in upper half, y in lower
    parameter logic [1:0] reg_addr_col = 2'd1;  // fg and bg, 4-bit rgb each
    parameter logic [1:0] reg_addr_ctl = 2'd2;  // bit 0 is sprite enable

    // one 32-bit write word decoded as position or as colour pair
    typedef union packed {
        struct packed {
            logic signed [cord_w-1:0] x;  // sprite left column
            logic signed [cord_w-1:0] y;  // sprite top line
        } pos;
        struct packed {
            logic [7:0]  rsvd;  // unused
            logic [11:0] fg;    // sprite colour
            logic [11:0] bg;    // background colour
        } col;
    } sprite_word_t;

    // reset defaults
    parameter logic signed [cord_w-1:0] def_sprx = 16'sd32;
    parameter logic signed [cord_w-1:0] def_spry = 16'sd16;
    parameter logic [11:0] def_fg = 12'hFC0;  // yellow
    parameter logic [11:0] def_bg = 12'h137;  // blue

endpackage

// File: design/display_timing.sv
// 640x480 display timing
// signed coordinates with blanking at negative values, de, frame and line pulses

`timescale 1ns/1ps

module display_timing (
    input  wire logic clk_pix,  // pixel clock
    input  wire logic rst_n,    // async reset, active low
    output      logic signed [sprite_pkg::cord_w-1:0] sx,  // horizontal position
    output      logic signed [sprite_pkg::cord_w-1:0] sy,  // vertical position
    output      logic de,     // data enable, low in blanking
    output      logic frame,  // one cycle at start of frame
    output      logic line    // one cycle at start of line
);

    // blanking starts, horizontal 160 pixels and vertical 45 lines
    localparam int h_sta = -160;
    localparam int v_sta = -45;

    // raw counters, outputs follow one cycle behind
    logic signed [sprite_pkg::cord_w-1:0] x;
    logic signed [sprite_pkg::cord_w-1:0] y;

    // step x every clock, y at the end of each line
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            x <= sprite_pkg::cord_w'(h_sta);
            y <= sprite_pkg::cord_w'(v_sta);
        end else begin
            if (x == sprite_pkg::h_res - 1) begin
                x <= sprite_pkg::cord_w'(h_sta);  // wrap into hblank
                if (y == sprite_pkg::v_res - 1) begin
                    y <= sprite_pkg::cord_w'(v_sta);  // back to top
                end else begin
                    y <= y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // decoded strobes, registered so they line up with sx and sy
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            de    <= 1'b0;
            frame <= 1'b0;
            line  <= 1'b0;
        end else begin
            de    <= (x >= 0) && (y >= 0);       // both inside active area
            frame <= (x == h_sta) && (y == v_sta);  // first blanking pixel
            line  <= (x == h_sta);
        end
    end

    // coordinate outputs
    always_ff @(posedge clk_pix) begin
        sx <= x;
        sy <= y;
    end

endmodule

// File: design/sprite_regs.sv
// sprite control registers
// pending copy takes writes, live copy follows at the frame pulse

`timescale 1ns/1ps

module sprite_regs (
    input  wire logic clk_pix,     // pixel clock
    input  wire logic rst_n,       // async reset, active low
    input  wire logic reg_we,      // write strobe, one cycle
    input  wire logic [1:0] reg_addr,            // register select
    input  wire sprite_pkg::sprite_word_t reg_wdata,  // write word
    input  wire logic frame,       // apply pending values
    output      logic signed [sprite_pkg::cord_w-1:0] sprx,  // live x
    output      logic signed [sprite_pkg::cord_w-1:0] spry,  // live y
    output      logic [11:0] fg,   // live sprite colour
    output      logic [11:0] bg,   // live background colour
    output      logic enable       // live sprite enable
);

    // pending copy
    logic signed [sprite_pkg::cord_w-1:0] pend_x;
    logic signed [sprite_pkg::cord_w-1:0] pend_y;
    logic [11:0] pend_fg;
    logic [11:0] pend_bg;
    logic pend_en;

    // write decode, view picked by address
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            pend_x  <= sprite_pkg::def_sprx;
            pend_y  <= sprite_pkg::def_spry;
            pend_fg <= sprite_pkg::def_fg;
            pend_bg <= sprite_pkg::def_bg;
            pend_en <= 1'b1;  // sprite shown out of reset
        end else if (reg_we) begin
            case (reg_addr)
                sprite_pkg::reg_addr_pos: begin
                    pend_x <= reg_wdata.pos.x;
                    pend_y <= reg_wdata.pos.y;
                end
                sprite_pkg::reg_addr_col: begin
                    pend_fg <= reg_wdata.col.fg;
                    pend_bg <= reg_wdata.col.bg;
                end
                sprite_pkg::reg_addr_ctl: begin
                    pend_en <= reg_wdata[0];
                end
                default: begin
                    // address 3 is a hole, write dropped
                end
            endcase
        end
    end

    // all fields move together so no frame is torn
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sprx   <= sprite_pkg::def_sprx;
            spry   <= sprite_pkg::def_spry;
            fg     <= sprite_pkg::def_fg;
            bg     <= sprite_pkg::def_bg;
            enable <= 1'b1;
        end else if (frame) begin
            sprx   <= pend_x;  // a write on this same edge waits a frame
            spry   <= pend_y;
            fg     <= pend_fg;
            bg     <= pend_bg;
            enable <= pend_en;
        end
    end

endmodule

// File: design/sprite_inline.sv
// single sprite engine with the 8x8 F bitmap held inline
// row latched per line, bit index stepped every sprite_scale pixels, 2 stage pipe

`timescale 1ns/1ps

module sprite_inline #(
    parameter int sprite_scale = 4  // integer magnification, 1, 2 or 4
) (
    input  wire logic clk_pix,  // pixel clock
    input  wire logic rst_n,    // async reset, active low
    input  wire logic signed [sprite_pkg::cord_w-1:0] sx,    // screen x
    input  wire logic signed [sprite_pkg::cord_w-1:0] sy,    // screen y
    input  wire logic de,       // data enable
    input  wire logic frame,    // start of frame
    input  wire logic line,     // start of line
    input  wire logic signed [sprite_pkg::cord_w-1:0] sprx,  // sprite left
    input  wire logic signed [sprite_pkg::cord_w-1:0] spry,  // sprite top
    input  wire logic enable,   // sprite on
    output      logic pix,      // bitmap bit under the pixel
    output      logic drawing,  // pixel falls inside the sprite
    output      logic signed [sprite_pkg::cord_w-1:0] sx_o,  // sx, 2 cycles late
    output      logic signed [sprite_pkg::cord_w-1:0] sy_o,  // sy, 2 cycles late
    output      logic de_o,     // de, 2 cycles late
    output      logic frame_o   // frame, 2 cycles late
);

    localparam int spr_w    = 8;
    localparam int spr_h    = 8;
    localparam int scale_sh = $clog2(sprite_scale);
    localparam int sub_w    = (sprite_scale > 1) ? scale_sh : 1;

    logic signed [sprite_pkg::cord_w-1:0] dy;  // line offset into sprite
    logic [sprite_pkg::cord_w-1:0] dy_scaled;  // offset in bitmap rows
    logic [2:0] row_idx;
    logic [7:0] row_rom;   // bitmap lookup, msb is leftmost
    logic [7:0] row_bits;  // row for the current line
    logic row_hit;         // current line crosses the sprite

    always_comb begin
        dy        = sy - spry;
        dy_scaled = dy >> scale_sh;
        row_idx   = dy_scaled[2:0];
    end

    // the F glyph
    always_comb begin
        case (row_idx)
            3'd0, 3'd1: row_rom = 8'b1111_1111;  // top bar
            3'd4:       row_rom = 8'b1111_1100;  // middle bar
            default:    row_rom = 8'b1000_0000;  // stem only
        endcase
    end

    // row check once per line, in hblank
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            row_hit  <= 1'b0;
            row_bits <= '0;
        end else if (line) begin
            row_hit  <= (dy >= 0) && (dy < spr_h * sprite_scale);
            row_bits <= row_rom;
        end
    end

    // horizontal walk state, describes the pixel one stage down
    logic run;
    logic [2:0] bit_idx;
    logic [sub_w-1:0] sub_cnt;  // pixels spent on the current bit
    logic active_x;
    logic start;
    logic run_n;
    logic [2:0] bit_n;
    logic [sub_w-1:0] sub_n;

    always_comb begin
        active_x = (sx >= 0) && (sx < sprite_pkg::h_res);
        start    = row_hit && active_x && (sx == sprx);
        run_n    = run;
        bit_n    = bit_idx;
        sub_n    = sub_cnt;
        if (!active_x) begin
            run_n = 1'b0;  // right edge clips, nothing wraps
        end else if (start) begin
            run_n = 1'b1;
            bit_n = '0;
            sub_n = '0;
        end else if (run) begin
            if (sub_cnt == sub_w'(sprite_scale - 1)) begin
                sub_n = '0;
                if (bit_idx == 3'(spr_w - 1)) begin
                    run_n = 1'b0;  // all 8 bits shown
                end else begin
                    bit_n = bit_idx + 3'd1;
                end
            end else begin
                sub_n = sub_cnt + 1'b1;
            end
        end
    end

    // stage 1 and stage 2 control
    logic de_d1;
    logic frame_d1;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            run      <= 1'b0;
            bit_idx  <= '0;
            sub_cnt  <= '0;
            de_d1    <= 1'b0;
            frame_d1 <= 1'b0;
            pix      <= 1'b0;
            drawing  <= 1'b0;
            de_o     <= 1'b0;
            frame_o  <= 1'b0;
        end else begin
            run      <= run_n;
            bit_idx  <= bit_n;
            sub_cnt  <= sub_n;
            de_d1    <= de;
            frame_d1 <= frame;
            pix      <= row_bits[3'd7 - bit_idx];  // walk left to right
            drawing  <= run && enable;
            de_o     <= de_d1;
            frame_o  <= frame_d1;
        end
    end

    // coordinates follow the same 2 stages
    logic signed [sprite_pkg::cord_w-1:0] sx_d1;
    logic signed [sprite_pkg::cord_w-1:0] sy_d1;

    always_ff @(posedge clk_pix) begin
        sx_d1 <= sx;
        sy_d1 <= sy;
        sx_o  <= sx_d1;
        sy_o  <= sy_d1;
    end

endmodule

// File: design/pixel_paint.sv
// paint stage with colour select, blanking and 4 to 8 bit widening
// registered output for the SDL viewer

`timescale 1ns/1ps

module pixel_paint (
    input  wire logic clk_pix,  // pixel clock
    input  wire logic rst_n,    // async reset, active low
    input  wire logic signed [sprite_pkg::cord_w-1:0] sx,  // aligned x
    input  wire logic signed [sprite_pkg::cord_w-1:0] sy,  // aligned y
    input  wire logic de,       // aligned data enable
    input  wire logic frame,    // aligned frame start
    input  wire logic drawing,  // inside sprite
    input  wire logic pix,      // bitmap bit
    input  wire logic [11:0] fg,  // sprite colour
    input  wire logic [11:0] bg,  // background colour
    output      logic signed [sprite_pkg::cord_w-1:0] sdl_sx,  // SDL x
    output      logic signed [sprite_pkg::cord_w-1:0] sdl_sy,  // SDL y
    output      logic sdl_de,       // SDL data enable
    output      logic sdl_frame,    // SDL frame start
    output      logic [7:0] sdl_r,  // red
    output      logic [7:0] sdl_g,  // green
    output      logic [7:0] sdl_b   // blue
);

    logic [11:0] paint;  // chosen 4-bit rgb
    logic [11:0] disp;   // black in blanking

    always_comb begin
        paint = (drawing && pix) ? fg : bg;
        disp  = de ? paint : 12'h000;
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sdl_de    <= 1'b0;
            sdl_frame <= 1'b0;
            sdl_r     <= '0;
            sdl_g     <= '0;
            sdl_b     <= '0;
        end else begin
            sdl_de    <= de;
            sdl_frame <= frame;
            sdl_r     <= {2{disp[11:8]}};  // nibble repeated so F becomes FF
            sdl_g     <= {2{disp[7:4]}};
            sdl_b     <= {2{disp[3:0]}};
        end
    end

    // coordinates ride along
    always_ff @(posedge clk_pix) begin
        sdl_sx <= sx;
        sdl_sy <= sy;
    end

endmodule

// File: design/sprite_display_top.sv
// sprite display top level
// timing, register block, sprite engine and paint stage

`timescale 1ns/1ps

module sprite_display_top #(
    parameter int sprite_scale = 4  // sprite magnification
) (
    input  wire logic clk_pix,    // pixel clock
    input  wire logic rst_n,      // async reset, active low
    input  wire logic reg_we,     // register write strobe
    input  wire logic [1:0] reg_addr,                 // register select
    input  wire sprite_pkg::sprite_word_t reg_wdata,  // register data
    output      logic signed [sprite_pkg::cord_w-1:0] sdl_sx,  // SDL x
    output      logic signed [sprite_pkg::cord_w-1:0] sdl_sy,  // SDL y
    output      logic sdl_de,       // SDL data enable
    output      logic sdl_frame,    // SDL frame start
    output      logic [7:0] sdl_r,  // red
    output      logic [7:0] sdl_g,  // green
    output      logic [7:0] sdl_b   // blue
);

    // raw timing
    logic signed [sprite_pkg::cord_w-1:0] sx;
    logic signed [sprite_pkg::cord_w-1:0] sy;
    logic de;
    logic frame;
    logic line;

    // live register values
    logic signed [sprite_pkg::cord_w-1:0] sprx;
    logic signed [sprite_pkg::cord_w-1:0] spry;
    logic [11:0] fg;
    logic [11:0] bg;
    logic enable;

    // sprite output bundle, 2 cycles behind timing
    logic pix;
    logic drawing;
    logic signed [sprite_pkg::cord_w-1:0] spr_sx;
    logic signed [sprite_pkg::cord_w-1:0] spr_sy;
    logic spr_de;
    logic spr_frame;  // also the register update point, after the last pixel

    display_timing i_display_timing (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sx      (sx),
        .sy      (sy),
        .de      (de),
        .frame   (frame),
        .line    (line)
    );

    sprite_regs i_sprite_regs (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .frame     (spr_frame),  // delayed pulse so paint never mixes frames
        .sprx      (sprx),
        .spry      (spry),
        .fg        (fg),
        .bg        (bg),
        .enable    (enable)
    );

    sprite_inline #(
        .sprite_scale (sprite_scale)
    ) i_sprite_inline (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sx      (sx),
        .sy      (sy),
        .de      (de),
        .frame   (frame),
        .line    (line),
        .sprx    (sprx),
        .spry    (spry),
        .enable  (enable),
        .pix     (pix),
        .drawing (drawing),
        .sx_o    (spr_sx),
        .sy_o    (spr_sy),
        .de_o    (spr_de),
        .frame_o (spr_frame)
    );

    pixel_paint i_pixel_paint (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .sx        (spr_sx),
        .sy        (spr_sy),
        .de        (spr_de),
        .frame     (spr_frame),
        .drawing   (drawing),
        .pix       (pix),
        .fg        (fg),
        .bg        (bg),
        .sdl_sx    (sdl_sx),
        .sdl_sy    (sdl_sy),
        .sdl_de    (sdl_de),
        .sdl_frame (sdl_frame),
        .sdl_r     (sdl_r),
        .sdl_g     (sdl_g),
        .sdl_b     (sdl_b)
    );

endmodule

// File: test/tb_sprite_display.sv
// testbench for the sprite display top level
// clock, reset, LFSR, stimulus table with expected pixels, pixel model, checks

`timescale 1ns/1ps

module tb_sprite_display;

    localparam int max_steps    = 12;
    localparam int max_smp      = 4;
    localparam int frame_cycles = (sprite_pkg::h_res + 160) * (sprite_pkg::v_res + 45);
    localparam int wait_limit   = frame_cycles + 64;  // one frame plus slack

    logic clk_pix;
    logic rst_n;
    logic reg_we;
    logic [1:0] reg_addr;
    sprite_pkg::sprite_word_t reg_wdata;
    logic signed [sprite_pkg::cord_w-1:0] sdl_sx;
    logic signed [sprite_pkg::cord_w-1:0] sdl_sy;
    logic sdl_de;
    logic sdl_frame;
    logic [7:0] sdl_r;
    logic [7:0] sdl_g;
    logic [7:0] sdl_b;

    // default scale, read back from the top level
    sprite_display_top i_sprite_display_top (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .sdl_sx    (sdl_sx),
        .sdl_sy    (sdl_sy),
        .sdl_de    (sdl_de),
        .sdl_frame (sdl_frame),
        .sdl_r     (sdl_r),
        .sdl_g     (sdl_g),
        .sdl_b     (sdl_b)
    );

    always #20 clk_pix = ~clk_pix;  // 40 ns period

    // stimulus table, one row per step
    logic step_wr [max_steps];    // do a register write first
    logic [1:0] step_addr [max_steps];
    sprite_pkg::sprite_word_t step_data [max_steps];
    logic step_wait [max_steps];  // wait for next frame before sampling
    int smp_n [max_steps];        // samples used in this row
    int smp_x [max_steps][max_smp];
    int smp_y [max_steps][max_smp];
    logic [23:0] smp_rgb [max_steps][max_smp];  // expected colour
    int n_steps;
    int scale;

    // model registers, pending and live
    int p_sprx;
    int p_spry;
    logic [11:0] p_fg;
    logic [11:0] p_bg;
    logic p_en;
    int m_sprx;
    int m_spry;
    logic [11:0] m_fg;
    logic [11:0] m_bg;
    logic m_en;

    logic [15:0] lfsr_state = 16'd55862;

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
    function automatic int take_bits(int n);
        int val;
        logic fb;
        val = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            val = (val << 1) | int'(fb);
        end
        return val;
    endfunction

    // F glyph, col 0 is leftmost
    function automatic logic glyph_bit(int row, int col);
        case (row)
            0, 1:    return 1'b1;      // top bar
            4:       return col < 6;   // middle bar
            default: return col == 0;  // stem
        endcase
    endfunction

    function automatic logic [23:0] model_rgb(int x, int y);
        logic [11:0] c;
        int col;
        int row;
        if (x < 0 || y < 0) begin
            return 24'h000000;  // blanking is black
        end
        c   = m_bg;
        col = x - m_sprx;
        row = y - m_spry;
        if (m_en && col >= 0 && row >= 0 && col < 8 * scale && row < 8 * scale) begin
            if (glyph_bit(row / scale, col / scale)) begin
                c = m_fg;
            end
        end
        return {c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]};  // nibble doubled
    endfunction

    function automatic sprite_pkg::sprite_word_t pos_word(int x, int y);
        sprite_pkg::sprite_word_t w;
        w.pos.x = sprite_pkg::cord_w'(x);
        w.pos.y = sprite_pkg::cord_w'(y);
        return w;
    endfunction

    function automatic sprite_pkg::sprite_word_t col_word(logic [11:0] fg, logic [11:0] bg);
        sprite_pkg::sprite_word_t w;
        w        = '0;
        w.col.fg = fg;
        w.col.bg = bg;
        return w;
    endfunction

    // new row, model follows the register rules
    function automatic void add_step(logic wr, logic [1:0] addr,
                                     sprite_pkg::sprite_word_t data, logic wt);
        step_wr[n_steps]   = wr;
        step_addr[n_steps] = addr;
        step_data[n_steps] = data;
        step_wait[n_steps] = wt;
        smp_n[n_steps]     = 0;
        n_steps            = n_steps + 1;
        if (wr) begin
            case (addr)
                sprite_pkg::reg_addr_pos: begin
                    p_sprx = data.pos.x;
                    p_spry = data.pos.y;
                end
                sprite_pkg::reg_addr_col: begin
                    p_fg = data.col.fg;
                    p_bg = data.col.bg;
                end
                sprite_pkg::reg_addr_ctl: p_en = data[0];
                default: ;  // hole
            endcase
        end
        if (wt) begin
            m_sprx = p_sprx;  // applied at the frame pulse
            m_spry = p_spry;
            m_fg   = p_fg;
            m_bg   = p_bg;
            m_en   = p_en;
        end
    endfunction

    // samples go in raster order within a frame
    function automatic void add_sample(int x, int y);
        int s;
        int k;
        s = n_steps - 1;
        k = smp_n[s];
        smp_x[s][k]   = x;
        smp_y[s][k]   = y;
        smp_rgb[s][k] = model_rgb(x, y);
        smp_n[s]      = k + 1;
    endfunction

    function automatic void build_table();
        int rx;
        int ry;
        n_steps = 0;
        p_sprx  = sprite_pkg::def_sprx;
        p_spry  = sprite_pkg::def_spry;
        p_fg    = sprite_pkg::def_fg;
        p_bg    = sprite_pkg::def_bg;
        p_en    = 1'b1;
        // default F after reset
        add_step(1'b0, 2'd0, 32'd0, 1'b1);
        add_sample(-100, -20);
        add_sample(32, 16);
        add_sample(32 + 2 * scale, 16 + 2 * scale);  // row 2 col 2, off glyph
        add_sample(32 + 5 * scale, 16 + 4 * scale);  // middle bar end
        // more blanking, same frame
        add_step(1'b0, 2'd0, 32'd0, 1'b0);
        add_sample(-160, 40);
        add_sample(-1, 40);
        add_sample(0, 40);
        add_sample(-50, 300);
        // mid-frame move, lower half so it would show in this frame if torn
        rx = take_bits(10) % (sprite_pkg::h_res - 8 * scale);
        ry = 310 + take_bits(7);
        add_step(1'b1, sprite_pkg::reg_addr_pos, pos_word(rx, ry), 1'b0);
        add_sample(rx, ry);
        add_sample(rx + 1, ry + 1);
        add_sample(600, 470);
        add_step(1'b0, 2'd0, 32'd0, 1'b1);
        add_sample(32, 16);
        add_sample(rx, ry);
        add_sample(rx + 4 * scale + 1, ry + 2 * scale + 1);
        add_sample(rx + 1, ry + 4 * scale + 2);
        // new colours
        add_step(1'b1, sprite_pkg::reg_addr_col, col_word(12'hE21, 12'h4A9), 1'b1);
        add_sample(-20, -10);
        add_sample(rx, ry);
        add_sample(rx + 4 * scale + 1, ry + 2 * scale + 1);
        add_sample(600, 470);
        // sprite off, then on again
        add_step(1'b1, sprite_pkg::reg_addr_ctl, 32'd0, 1'b1);
        add_sample(0, 0);
        add_sample(rx, ry);
        add_sample(rx + 1, ry + 1);
        add_sample(rx + 1, ry + 4 * scale + 2);
        add_step(1'b1, sprite_pkg::reg_addr_ctl, 32'd1, 1'b1);
        add_sample(rx, ry);
        add_sample(rx + 1, ry + 1);
        add_sample(rx + 4 * scale + 1, ry + 2 * scale + 1);
        add_sample(rx + 1, ry + 4 * scale + 2);
        // right edge clip, next line start must stay background
        add_step(1'b1, sprite_pkg::reg_addr_pos, pos_word(620, 100), 1'b1);
        add_sample(620, 100);
        add_sample(639, 100);
        add_sample(0, 101);
        add_sample(624, 108);
        add_step(1'b0, 2'd0, 32'd0, 1'b0);
        add_sample(0, 109);
        add_sample(623, 112);
        add_sample(636, 116);
        add_sample(639, 116);
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    // one strobe, driven just after the edge
    task automatic reg_write(input logic [1:0] addr, input sprite_pkg::sprite_word_t data);
        @(posedge clk_pix);
        #2;
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk_pix);
        #2;
        reg_we    = 1'b0;
    endtask

    task automatic wait_frame();
        int n;
        n = 0;
        @(negedge clk_pix);
        while (sdl_frame !== 1'b1) begin
            if (n > wait_limit) begin
                fail_stop("timeout waiting for sdl_frame");
            end
            n = n + 1;
            @(negedge clk_pix);
        end
        check_value("sdl_sx at frame", 32'(sdl_sx), 32'(-160));
        check_value("sdl_sy at frame", 32'(sdl_sy), 32'(-45));
        check_value("sdl_de at frame", 32'(sdl_de), 32'd0);
        check_value("sdl_rgb at frame", 32'({sdl_r, sdl_g, sdl_b}), 32'd0);
    endtask

    // sampled on the falling edge, well clear of output changes
    task automatic check_pixel(input int x, input int y, input logic [23:0] exp);
        int n;
        n = 0;
        @(negedge clk_pix);
        while (sdl_sx !== sprite_pkg::cord_w'(x) || sdl_sy !== sprite_pkg::cord_w'(y)) begin
            if (n > wait_limit) begin
                fail_stop($sformatf("timeout waiting for pixel (%0d,%0d)", x, y));
            end
            n = n + 1;
            @(negedge clk_pix);
        end
        check_value($sformatf("sdl_de at (%0d,%0d)", x, y), 32'(sdl_de),
                    32'(x >= 0 && y >= 0));
        check_value($sformatf("sdl_rgb at (%0d,%0d)", x, y),
                    32'({sdl_r, sdl_g, sdl_b}), 32'(exp));
    endtask

    initial begin
        clk_pix   = 1'b0;
        rst_n     = 1'b0;
        reg_we    = 1'b0;
        reg_addr  = 2'd0;
        reg_wdata = '0;
        scale     = i_sprite_display_top.sprite_scale;
        build_table();
        repeat (8) @(posedge clk_pix);
        #2;
        rst_n = 1'b1;
        for (int s = 0; s < n_steps; s++) begin
            if (step_wr[s]) begin
                reg_write(step_addr[s], step_data[s]);
            end
            if (step_wait[s]) begin
                wait_frame();
            end
            for (int k = 0; k < smp_n[s]; k++) begin
                check_pixel(smp_x[s][k], smp_y[s][k], smp_rgb[s][k]);
            end
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: files.f
design/sprite_pkg.sv
design/display_timing.sv
design/sprite_regs.sv
design/sprite_inline.sv
design/pixel_paint.sv
design/sprite_display_top.sv
test/tb_sprite_display.sv

// File: Makefile
# Verilator flow for the sprite display testbench
# pass or fail is taken from run.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_sprite_display \
		-f files.f -o sim_sprite_display

run: compile
	./obj_dir/sim_sprite_display | tee run.log
	grep -q ">>> PASS" run.log

clean:
	rm -rf obj_dir run.log
